/* include/tcdm_defines.svh */
// TCDM subsystem sizes: masters, banks, address and data widths, bank depth
`ifndef TCDM_DEFINES_SVH
`define TCDM_DEFINES_SVH

//////////////////////////////
// Subsystem dimensions
//////////////////////////////

// Masters sharing the data memory
`define TCDM_NUM_MASTERS 4
// Word-interleaved memory banks
`define TCDM_NUM_BANKS 2
// Word address width seen by every master
`define TCDM_ADDR_W 10
`define TCDM_DATA_W 32
// Words stored in one bank
`define TCDM_BANK_DEPTH 256

//////////////////////////////
// Address split
//////////////////////////////

// Lowest word-address bit that picks the bank
`define TCDM_BANK_SEL_BIT 0
// Bits needed for a bank index
`define TCDM_BANK_IDX_W ($clog2(`TCDM_NUM_BANKS))
// Row bits inside one bank, taken just above the bank index
`define TCDM_ROW_W ($clog2(`TCDM_BANK_DEPTH))

`endif

/* list.f */
+incdir+include
source/tcdm_bus_pkg.sv
source/tcdm_arb_pkg.sv
source/prio_flag_gen.sv
source/bank_req_decode.sv
source/bank_arbiter.sv
source/tcdm_bank.sv
source/tcdm_resp_route.sv
source/tcdm_xbar_top.sv
test/tcdm_xbar_checker.sv
test/tcdm_xbar_tb.sv

/* run.sh */
#!/bin/sh
# Build the TCDM crossbar simulation with Verilator and run it from the project root

cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -f list.f --top-module tcdm_xbar_tb -o tcdm_xbar_sim &&
./obj_dir/tcdm_xbar_sim | tee sim.log ||
echo "Build or simulation step returned an error"

# Result comes from the simulation log only
grep -q "SIMULATION PASSED" sim.log && echo "run.sh: pass" ||
{ echo "run.sh: fail"; exit 1; }

/* source/bank_arbiter.sv */
// Bank arbiter: picks one requesting master by scanning from the priority flag
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module bank_arbiter
(
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  tcdm_arb_pkg::arb_policy_e                         policy_i,
   input  logic [`TCDM_NUM_MASTERS-1:0]                      req_lines_i,
   input  tcdm_bus_pkg::tcdm_req_t [`TCDM_NUM_MASTERS-1:0]   req_bus_i,
   output logic [`TCDM_NUM_MASTERS-1:0]                      gnt_o,
   output tcdm_bus_pkg::tcdm_req_t                           win_req_o,
   output tcdm_arb_pkg::master_idx_t                         win_idx_o
);

   tcdm_arb_pkg::master_idx_t flag;
   tcdm_arb_pkg::master_idx_t win_idx;
   logic                      win_found;

   // Arbitration pointer, only moves when this bank grants
   prio_flag_gen prio_flag_gen_i
   (
      .clk           ( clk       ),
      .rst_n         ( rst_n     ),
      .policy_i      ( policy_i  ),
      .grant_valid_i ( win_found ),
      .winner_i      ( win_idx   ),
      .flag_o        ( flag      )
   );

   //////////////////////////////
   // Priority scan
   //////////////////////////////

   // Start right after the flag, wrap, and end on the flag itself
   // First request line hit in that order wins
   always_comb
   begin : scan_comb
      int unsigned cand;
      win_found = 1'b0;
      win_idx   = '0;
      for (int unsigned off = 1; off <= `TCDM_NUM_MASTERS; off++)
      begin
         cand = (flag + off) % `TCDM_NUM_MASTERS;
         if (!win_found && req_lines_i[cand])
         begin
            win_found = 1'b1;
            win_idx   = tcdm_arb_pkg::master_idx_t'(cand);
         end
      end
   end

   //////////////////////////////
   // Grant and forward
   //////////////////////////////

   // One-hot grant back to the masters
   always_comb
   begin : gnt_comb
      gnt_o = '0;
      if (win_found)
         gnt_o[win_idx] = 1'b1;
   end

   // Winner's request to the bank, strobe only when someone won
   always_comb
   begin : fwd_comb
      win_req_o     = req_bus_i[win_idx];
      win_req_o.req = win_found;
   end

   assign win_idx_o = win_idx;

endmodule

/* source/bank_req_decode.sv */
// Bank request decoder: maps one master onto a bank and returns that bank's grant
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module bank_req_decode
(
   input  tcdm_bus_pkg::tcdm_req_t    req_i,
   output logic [`TCDM_NUM_BANKS-1:0] bank_sel_o,
   input  logic [`TCDM_NUM_BANKS-1:0] bank_gnt_i,
   output logic                       gnt_o
);

   // Bank named by the interleave bits of the word address
   logic [`TCDM_BANK_IDX_W-1:0] bank_idx;

   assign bank_idx = req_i.addr[`TCDM_BANK_SEL_BIT +: `TCDM_BANK_IDX_W];

   //////////////////////////////
   // Bank select
   //////////////////////////////

   // One-hot select, all zero while the master is idle
   always_comb
   begin : sel_comb
      bank_sel_o = '0;
      for (int b = 0; b < `TCDM_NUM_BANKS; b++)
      begin
         if (req_i.req && (bank_idx == b))
         begin
            bank_sel_o[b] = 1'b1;
         end
      end
   end

   //////////////////////////////
   // Grant return
   //////////////////////////////

   // Only the addressed bank can grant this master
   // Other banks' grant bits are never looked at
   assign gnt_o = bank_gnt_i[bank_idx];

endmodule

/* source/prio_flag_gen.sv */
// Priority flag generator: arbitration pointer of one bank, moved only on a granted request
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module prio_flag_gen
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  tcdm_arb_pkg::arb_policy_e policy_i,
   input  logic                      grant_valid_i,
   input  tcdm_arb_pkg::master_idx_t winner_i,
   output tcdm_arb_pkg::master_idx_t flag_o
);

   // Highest master index, the wrap point of the round-robin count
   localparam tcdm_arb_pkg::master_idx_t MAX_FLAG =
      tcdm_arb_pkg::master_idx_t'(`TCDM_NUM_MASTERS - 1);

   tcdm_arb_pkg::master_idx_t flag_q;

   //////////////////////////////
   // Flag register
   //////////////////////////////

   // Idle banks leave the flag alone, so no toggling without traffic
   always_ff @(posedge clk, negedge rst_n)
   begin : flag_seq
      if (!rst_n)
      begin
         flag_q <= '0;
      end
      else if (grant_valid_i)
      begin
         if (policy_i == tcdm_arb_pkg::ARB_ROUND_ROBIN)
         begin
            // Free-running count, wraps back to master 0
            if (flag_q == MAX_FLAG)
               flag_q <= '0;
            else
               flag_q <= flag_q + 1'b1;
         end
         else
         begin
            // Park on the winner, it gets lowest priority next time
            flag_q <= winner_i;
         end
      end
   end

   assign flag_o = flag_q;

endmodule

/* source/tcdm_arb_pkg.sv */
// TCDM arbitration package: policy encoding and master index type
`include "tcdm_defines.svh"

package tcdm_arb_pkg;

   // Index of one master, also the width of a priority flag
   typedef logic [$clog2(`TCDM_NUM_MASTERS)-1:0] master_idx_t;

   // Arbitration policy, a level selected from outside
   // Round robin moves the flag by one on each grant
   // Last winner parks the flag on the master just granted
   typedef enum logic {
      ARB_ROUND_ROBIN = 1'b0,
      ARB_LAST_WINNER = 1'b1
   } arb_policy_e;

endpackage

/* source/tcdm_bank.sv */
// TCDM bank: single-port word storage with registered read and response strobe
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_bank
(
   input  logic                     clk,
   input  logic                     rst_n,
   input  tcdm_bus_pkg::tcdm_req_t  req_i,
   output tcdm_bus_pkg::tcdm_resp_t resp_o
);

   // Row bits sit just above the bank interleave bits
   localparam int ROW_LSB = `TCDM_BANK_SEL_BIT + `TCDM_BANK_IDX_W;

   logic [`TCDM_DATA_W-1:0] mem_q [`TCDM_BANK_DEPTH];
   logic [`TCDM_ROW_W-1:0]  row;
   logic [`TCDM_DATA_W-1:0] rdata_q;
   logic                    r_valid_q;

   // Upper address bits beyond the bank depth alias onto lower rows
   assign row = req_i.addr[ROW_LSB +: `TCDM_ROW_W];

   //////////////////////////////
   // Storage array
   //////////////////////////////

   // Cleared at reset, unwritten rows read back as zero
   always_ff @(posedge clk, negedge rst_n)
   begin : mem_seq
      if (!rst_n)
      begin
         for (int i = 0; i < `TCDM_BANK_DEPTH; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else if (req_i.req && req_i.we)
      begin
         mem_q[row] <= req_i.wdata;
      end
   end

   //////////////////////////////
   // Read port and strobe
   //////////////////////////////

   // Read word captured on the grant edge
   // Writes leave the old value in place
   always_ff @(posedge clk)
   begin : rdata_seq
      if (req_i.req && !req_i.we)
         rdata_q <= mem_q[row];
   end

   // One strobe per accepted transfer, one cycle later
   always_ff @(posedge clk, negedge rst_n)
   begin : rvalid_seq
      if (!rst_n)
         r_valid_q <= 1'b0;
      else
         r_valid_q <= req_i.req;
   end

   assign resp_o.r_valid = r_valid_q;
   assign resp_o.rdata   = rdata_q;

endmodule

/* source/tcdm_bus_pkg.sv */
// TCDM bus package: request and response structs moved between masters, arbiters and banks
`include "tcdm_defines.svh"

package tcdm_bus_pkg;

   //////////////////////////////
   // Request side
   //////////////////////////////

   // One master request
   // Held stable by the master until its grant is seen
   typedef struct packed {
      // Request strobe
      logic                    req;
      // High for a write, low for a read
      logic                    we;
      // Word address, bank bits and row bits together
      logic [`TCDM_ADDR_W-1:0] addr;
      // Store data, ignored on reads
      logic [`TCDM_DATA_W-1:0] wdata;
   } tcdm_req_t;

   //////////////////////////////
   // Response side
   //////////////////////////////

   // One response, one cycle after the granted transfer
   typedef struct packed {
      // Response strobe, for reads and writes alike
      logic                    r_valid;
      // Read word, don't care after a write
      logic [`TCDM_DATA_W-1:0] rdata;
   } tcdm_resp_t;

endpackage

/* source/tcdm_resp_route.sv */
// TCDM response router: sends each bank response back to the master it granted
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_resp_route
(
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  logic [`TCDM_NUM_BANKS-1:0]                        bank_gnt_valid_i,
   input  tcdm_arb_pkg::master_idx_t [`TCDM_NUM_BANKS-1:0]   bank_win_idx_i,
   input  tcdm_bus_pkg::tcdm_resp_t [`TCDM_NUM_BANKS-1:0]    bank_resp_i,
   output tcdm_bus_pkg::tcdm_resp_t [`TCDM_NUM_MASTERS-1:0]  resp_o
);

   logic [`TCDM_NUM_BANKS-1:0]                      gnt_valid_q;
   tcdm_arb_pkg::master_idx_t [`TCDM_NUM_BANKS-1:0] win_idx_q;

   //////////////////////////////
   // Winner tracking
   //////////////////////////////

   // Grant of this cycle lines up with the bank response of the next
   always_ff @(posedge clk, negedge rst_n)
   begin : win_seq
      if (!rst_n)
      begin
         gnt_valid_q <= '0;
         win_idx_q   <= '0;
      end
      else
      begin
         gnt_valid_q <= bank_gnt_valid_i;
         for (int b = 0; b < `TCDM_NUM_BANKS; b++)
         begin
            // Index only matters when the bank granted
            if (bank_gnt_valid_i[b])
               win_idx_q[b] <= bank_win_idx_i[b];
         end
      end
   end

   //////////////////////////////
   // Response steering
   //////////////////////////////

   // A master addresses one bank at a time, so no two banks collide here
   always_comb
   begin : route_comb
      resp_o = '0;
      for (int b = 0; b < `TCDM_NUM_BANKS; b++)
      begin
         if (gnt_valid_q[b])
            resp_o[win_idx_q[b]] = bank_resp_i[b];
      end
   end

endmodule

/* source/tcdm_xbar_top.sv */
// TCDM crossbar top: decoders, per-bank arbiters, banks and response router
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_xbar_top
(
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  tcdm_arb_pkg::arb_policy_e                         arb_policy_i,
   input  tcdm_bus_pkg::tcdm_req_t [`TCDM_NUM_MASTERS-1:0]   req_i,
   output logic [`TCDM_NUM_MASTERS-1:0]                      gnt_o,
   output tcdm_bus_pkg::tcdm_resp_t [`TCDM_NUM_MASTERS-1:0]  resp_o
);

   // Master-major and bank-major views of the same request and grant lines
   logic [`TCDM_NUM_MASTERS-1:0][`TCDM_NUM_BANKS-1:0] bank_sel;
   logic [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_MASTERS-1:0] req_lines;
   logic [`TCDM_NUM_BANKS-1:0][`TCDM_NUM_MASTERS-1:0] arb_gnt;
   logic [`TCDM_NUM_MASTERS-1:0][`TCDM_NUM_BANKS-1:0] bank_gnt;

   tcdm_bus_pkg::tcdm_req_t [`TCDM_NUM_BANKS-1:0]   win_req;
   tcdm_arb_pkg::master_idx_t [`TCDM_NUM_BANKS-1:0] win_idx;
   logic [`TCDM_NUM_BANKS-1:0]                      bank_gnt_valid;
   tcdm_bus_pkg::tcdm_resp_t [`TCDM_NUM_BANKS-1:0]  bank_resp;

   //////////////////////////////
   // Master side
   //////////////////////////////

   for (genvar m = 0; m < `TCDM_NUM_MASTERS; m++)
   begin : gen_master
      bank_req_decode decode_i
      (
         .req_i      ( req_i[m]    ),
         .bank_sel_o ( bank_sel[m] ),
         .bank_gnt_i ( bank_gnt[m] ),
         .gnt_o      ( gnt_o[m]    )
      );

      // Transpose between master-major and bank-major views
      for (genvar b = 0; b < `TCDM_NUM_BANKS; b++)
      begin : gen_xpose
         assign req_lines[b][m] = bank_sel[m][b];
         assign bank_gnt[m][b]  = arb_gnt[b][m];
      end
   end

   //////////////////////////////
   // Bank side
   //////////////////////////////

   for (genvar b = 0; b < `TCDM_NUM_BANKS; b++)
   begin : gen_bank
      bank_arbiter arb_i
      (
         .clk         ( clk          ),
         .rst_n       ( rst_n        ),
         .policy_i    ( arb_policy_i ),
         .req_lines_i ( req_lines[b] ),
         .req_bus_i   ( req_i        ),
         .gnt_o       ( arb_gnt[b]   ),
         .win_req_o   ( win_req[b]   ),
         .win_idx_o   ( win_idx[b]   )
      );

      // Bank grants whenever its winner strobe is up
      assign bank_gnt_valid[b] = win_req[b].req;

      tcdm_bank bank_i
      (
         .clk    ( clk          ),
         .rst_n  ( rst_n        ),
         .req_i  ( win_req[b]   ),
         .resp_o ( bank_resp[b] )
      );
   end

   tcdm_resp_route resp_route_i
   (
      .clk              ( clk            ),
      .rst_n            ( rst_n          ),
      .bank_gnt_valid_i ( bank_gnt_valid ),
      .bank_win_idx_i   ( win_idx        ),
      .bank_resp_i      ( bank_resp      ),
      .resp_o           ( resp_o         )
   );

endmodule

/* test/tcdm_xbar_checker.sv */
// TCDM crossbar checker: reference model of arbitration and memory, compare and per-test report
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_xbar_checker
(
   input  logic                                              clk,
   input  logic                                              rst_n,
   input  logic [3:0]                                        test_id_i,
   input  tcdm_arb_pkg::arb_policy_e                         policy_i,
   input  tcdm_bus_pkg::tcdm_req_t [`TCDM_NUM_MASTERS-1:0]   req_i,
   input  logic [`TCDM_NUM_MASTERS-1:0]                      gnt_i,
   input  tcdm_bus_pkg::tcdm_resp_t [`TCDM_NUM_MASTERS-1:0]  resp_i,
   output int                                                err_total_o,
   output int                                                tests_failed_o
);

   localparam int NM = `TCDM_NUM_MASTERS;
   localparam int NB = `TCDM_NUM_BANKS;

   //////////////////////////////
   // Model state
   //////////////////////////////

   // Priority flag per bank, kept across policy changes
   int                      flag [NB];
   // Whole word address space, bank and row bits together
   logic [`TCDM_DATA_W-1:0] mem_img [1 << `TCDM_ADDR_W];
   // Response owed to each master on the next edge
   logic [NM-1:0]           pend_valid;
   logic [NM-1:0]           pend_we;
   logic [`TCDM_DATA_W-1:0] pend_rdata [NM];
   // Requests left waiting at the last edge
   logic [NM-1:0]           held;
   tcdm_bus_pkg::tcdm_req_t held_req [NM];

   // Per-test and overall counts
   logic [3:0] cur_test     = 4'd0;
   int         err_total    = 0;
   int         tests_failed = 0;
   int         test_errs    = 0;
   int         test_cycles  = 0;
   int         dual_grants  = 0;
   int         long_waits   = 0;
   int         grant_cnt [NM];
   int         wait_cnt [NM];

   assign err_total_o    = err_total;
   assign tests_failed_o = tests_failed;

   function automatic string test_name(input logic [3:0] id);
      case (id)
         4'd1:    return "reset_state";
         4'd2:    return "round_robin_grants";
         4'd3:    return "last_winner_grants";
         4'd4:    return "bank_parallelism";
         4'd5:    return "data_integrity";
         4'd6:    return "back_pressure";
         default: return "idle";
      endcase
   endfunction

   // Bank picked by the interleave bit of the word address
   function automatic int bank_of(input tcdm_bus_pkg::tcdm_req_t q);
      return int'(q.addr[`TCDM_BANK_SEL_BIT]);
   endfunction

   task automatic record_error(input string msg);
      $display("%s", msg);
      test_errs++;
      err_total++;
   endtask

   task automatic start_test();
      test_errs   = 0;
      test_cycles = 0;
      dual_grants = 0;
      long_waits  = 0;
      for (int m = 0; m < NM; m++)
         grant_cnt[m] = 0;
   endtask

   //////////////////////////////
   // Test close
   //////////////////////////////

   // Traffic goals of a test, then its result line
   task automatic report_test(input logic [3:0] id);
      if (id == 4'd2 || id == 4'd3)
      begin
         for (int m = 0; m < NM; m++)
         begin
            if (grant_cnt[m] == 0)
               record_error($sformatf("Test %s: master %0d was never granted",
                                      test_name(id), m));
         end
      end
      if (id == 4'd4 && dual_grants == 0)
         record_error("Test bank_parallelism: no cycle granted both banks at once");
      if (id == 4'd6 && long_waits == 0)
         record_error("Test back_pressure: no request was held for three cycles");
      if (test_errs != 0)
         tests_failed++;
      $display("Test %s finished after %0d cycles with %0d errors",
               test_name(id), test_cycles, test_errs);
   endtask

   //////////////////////////////
   // Per-cycle model and compare
   //////////////////////////////

   // Sampled values are the ones from just before the edge
   always @(posedge clk)
   begin : model_check
      logic [NM-1:0]             exp_gnt;
      logic                      found;
      int                        cand;
      tcdm_arb_pkg::master_idx_t winner;
      int                        banks_granted;
      if (test_id_i != cur_test)
      begin
         if (cur_test >= 4'd1 && cur_test <= 4'd6)
            report_test(cur_test);
         start_test();
         cur_test = test_id_i;
      end
      if (!rst_n)
      begin
         for (int b = 0; b < NB; b++)
            flag[b] = 0;
         for (int i = 0; i < (1 << `TCDM_ADDR_W); i++)
            mem_img[i] = '0;
         for (int m = 0; m < NM; m++)
            wait_cnt[m] = 0;
         pend_valid = '0;
         pend_we    = '0;
         held       = '0;
      end
      else
      begin
         test_cycles++;
         // Responses owed from the previous edge, read data only after reads
         for (int m = 0; m < NM; m++)
         begin
            if (resp_i[m].r_valid !== pend_valid[m])
               record_error($sformatf("FAILED %s: r_valid of master %0d expected %b actual %b",
                                      test_name(cur_test), m, pend_valid[m], resp_i[m].r_valid));
            else if (pend_valid[m] && !pend_we[m] && resp_i[m].rdata !== pend_rdata[m])
               record_error($sformatf("FAILED %s: rdata of master %0d expected %h actual %h",
                                      test_name(cur_test), m, pend_rdata[m], resp_i[m].rdata));
         end
         // Scan from flag plus one, wrapping, ending on the flag
         exp_gnt       = '0;
         banks_granted = 0;
         for (int b = 0; b < NB; b++)
         begin
            found  = 1'b0;
            winner = '0;
            for (int k = 1; k <= NM; k++)
            begin
               cand = (flag[b] + k) % NM;
               if (!found && req_i[tcdm_arb_pkg::master_idx_t'(cand)].req &&
                   bank_of(req_i[tcdm_arb_pkg::master_idx_t'(cand)]) == b)
               begin
                  found  = 1'b1;
                  winner = tcdm_arb_pkg::master_idx_t'(cand);
               end
            end
            if (found)
            begin
               exp_gnt[winner] = 1'b1;
               banks_granted++;
               if (policy_i == tcdm_arb_pkg::ARB_ROUND_ROBIN)
                  flag[b] = (flag[b] + 1) % NM;
               else
                  flag[b] = int'(winner);
            end
         end
         if (gnt_i !== exp_gnt)
            record_error($sformatf("FAILED %s: gnt expected %b actual %b",
                                   test_name(cur_test), exp_gnt, gnt_i));
         for (int m = 0; m < NM; m++)
         begin
            if (gnt_i[m] && !req_i[m].req)
               record_error($sformatf("Test %s: master %0d granted while its request was low",
                                      test_name(cur_test), m));
         end
         // Granted transfers enter the model, read word taken before any write
         for (int m = 0; m < NM; m++)
         begin
            pend_valid[m] = exp_gnt[m];
            pend_we[m]    = req_i[m].we;
            pend_rdata[m] = mem_img[req_i[m].addr];
            if (exp_gnt[m] && req_i[m].we)
               mem_img[req_i[m].addr] = req_i[m].wdata;
         end
         // Waiting requests must stay exactly as issued
         for (int m = 0; m < NM; m++)
         begin
            if (held[m] && req_i[m] !== held_req[m])
               record_error($sformatf("Test %s: master %0d changed a request still waiting",
                                      test_name(cur_test), m));
            held[m]     = req_i[m].req && !gnt_i[m];
            held_req[m] = req_i[m];
            if (held[m])
            begin
               wait_cnt[m]++;
               if (wait_cnt[m] == 3)
                  long_waits++;
            end
            else
               wait_cnt[m] = 0;
            if (gnt_i[m])
               grant_cnt[m]++;
         end
         if (banks_granted == NB)
            dual_grants++;
      end
   end

endmodule

/* test/tcdm_xbar_tb.sv */
// TCDM crossbar testbench that drives clock, reset and seeded random masters under a run watchdog
`timescale 1ns/10ps
`include "tcdm_defines.svh"

module tcdm_xbar_tb;

   localparam int NM           = `TCDM_NUM_MASTERS;
   localparam int RESET_CYCLES = 10;
   // Request cycles per test before the drain
   localparam int LEN_RESET    = 8;
   localparam int LEN_RR       = 40;
   localparam int LEN_LW       = 40;
   localparam int LEN_PAR      = 60;
   localparam int LEN_DATA     = 80;
   localparam int LEN_BP       = 40;
   localparam int NUM_TESTS    = 6;
   localparam int TEST_CYCLES  = RESET_CYCLES + LEN_RESET + LEN_RR + LEN_LW +
                                 LEN_PAR + LEN_DATA + LEN_BP;
   localparam int CYCLE_LIMIT  = 2 * TEST_CYCLES;

   logic                              clk;
   logic                              rst_n;
   tcdm_arb_pkg::arb_policy_e         policy;
   tcdm_bus_pkg::tcdm_req_t [NM-1:0]  req;
   logic [NM-1:0]                     gnt;
   tcdm_bus_pkg::tcdm_resp_t [NM-1:0] resp;
   // Grants seen on the last rising edge
   logic [NM-1:0]                     gnt_seen = '0;
   logic [3:0]                        test_id;
   int                                seed = 31428;
   int                                cycle_cnt = 0;
   int                                err_total;
   int                                tests_failed;

   tcdm_xbar_top tcdm_xbar_top_i
   (
      .clk          ( clk    ),
      .rst_n        ( rst_n  ),
      .arb_policy_i ( policy ),
      .req_i        ( req    ),
      .gnt_o        ( gnt    ),
      .resp_o       ( resp   )
   );

   tcdm_xbar_checker tcdm_xbar_checker_i
   (
      .clk            ( clk          ),
      .rst_n          ( rst_n        ),
      .test_id_i      ( test_id      ),
      .policy_i       ( policy       ),
      .req_i          ( req          ),
      .gnt_i          ( gnt          ),
      .resp_i         ( resp         ),
      .err_total_o    ( err_total    ),
      .tests_failed_o ( tests_failed )
   );

   always #50 clk = ~clk;

   always @(posedge clk)
   begin : grant_sample
      gnt_seen = gnt;
   end

   //////////////////////////////
   // Watchdog
   //////////////////////////////

   always @(posedge clk)
   begin : watchdog
      cycle_cnt++;
      if (cycle_cnt >= CYCLE_LIMIT)
      begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   // Bit 9 stays clear
   // Bit 8 keeps this traffic away from the data test's low words
   function automatic tcdm_bus_pkg::tcdm_req_t new_request(input logic [3:0] id,
      input int cyc, input int len, input logic [31:0] r, input logic [31:0] d);
      tcdm_bus_pkg::tcdm_req_t q;
      q       = '0;
      q.we    = r[9];
      q.addr  = {2'b01, r[7:1], r[8]};
      q.wdata = d;
      case (id)
         4'd2, 4'd6:
         begin
            q.req     = 1'b1;
            q.addr[0] = 1'b0;
         end
         4'd3:
         begin
            // Gaps in the traffic let the two policies pick different winners
            q.req     = r[10] | r[11];
            q.addr[0] = 1'b1;
         end
         4'd4: q.req = r[10];
         4'd5:
         begin
            q.req = r[10] | r[11];
            // Writes into words 0..31 in the first half and reads over 0..63 in the second
            if (cyc < len / 2)
            begin
               q.we   = 1'b1;
               q.addr = {5'd0, r[4:0]};
            end
            else
            begin
               q.we   = 1'b0;
               q.addr = {4'd0, r[5:0]};
            end
         end
         default: q.req = 1'b0;
      endcase
      if (!q.req)
         q = '0;
      return q;
   endfunction

   // Last-winner test drops to round robin for one quarter
   function automatic tcdm_arb_pkg::arb_policy_e pick_policy(input logic [3:0] id,
      input int cyc, input int len, input logic r);
      if (id == 4'd3)
      begin
         if (cyc >= len / 2 && cyc < (3 * len) / 4)
            return tcdm_arb_pkg::ARB_ROUND_ROBIN;
         return tcdm_arb_pkg::ARB_LAST_WINNER;
      end
      if (id == 4'd6)
         return tcdm_arb_pkg::arb_policy_e'(r);
      return tcdm_arb_pkg::ARB_ROUND_ROBIN;
   endfunction

   // A request stays up unchanged until its grant has been seen
   task automatic drive_masters(input logic [3:0] id, input int cyc, input int len,
                                input logic allow_new);
      logic [31:0] r;
      logic [31:0] d;
      for (int m = 0; m < NM; m++)
      begin
         r = $random(seed);
         d = $random(seed);
         if (!req[m].req || gnt_seen[m])
         begin
            if (allow_new)
               req[m] = new_request(id, cyc, len, r, d);
            else
               req[m] = '0;
         end
      end
   endtask

   function automatic logic req_pending();
      logic any;
      any = 1'b0;
      for (int m = 0; m < NM; m++)
         any = any | req[m].req;
      return any;
   endfunction

   task automatic run_test(input logic [3:0] id, input int len);
      logic [31:0] r;
      test_id = id;
      for (int cyc = 0; cyc < len; cyc++)
      begin
         @(negedge clk);
         r      = $random(seed);
         policy = pick_policy(id, cyc, len, r[0]);
         drive_masters(id, cyc, len, 1'b1);
      end
      // Drain until every held request got its grant
      do
      begin
         @(negedge clk);
         drive_masters(id, len, len, 1'b0);
      end
      while (req_pending());
      // Room for the last responses
      repeat (2) @(negedge clk);
   endtask

   initial
   begin : main
      clk     = 1'b0;
      rst_n   = 1'b0;
      policy  = tcdm_arb_pkg::ARB_ROUND_ROBIN;
      req     = '0;
      test_id = 4'd0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      run_test(4'd1, LEN_RESET);
      run_test(4'd2, LEN_RR);
      run_test(4'd3, LEN_LW);
      run_test(4'd4, LEN_PAR);
      run_test(4'd5, LEN_DATA);
      run_test(4'd6, LEN_BP);
      // Lets the checker close the last test
      test_id = 4'd7;
      repeat (2) @(negedge clk);
      $display("Summary: %0d tests run, %0d failed, %0d errors",
               NUM_TESTS, tests_failed, err_total);
      if (err_total == 0 && tests_failed == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

endmodule
